//--- bus_arbiter.sv
module bus_arbiter import soc_pkg::*; (
    input  logic      pll_clk,
    input  logic      rst_n,

    input  addr_t     instr_address,
    input  logic      instr_read,
    output data_t     instr_read_value,
    output logic      instr_ready,

    input  addr_t     data_address,
    input  logic      data_read,
    input  logic      data_write,
    input  mask_t     data_write_mask,
    input  data_t     data_write_value,
    output data_t     data_read_value,
    output logic      data_ready,

    mem_bus_if.master bus
);

    typedef enum logic {
        st_idle,
        st_access
    } state_e;

    state_e  state;
    periph_e sel_q;
    periph_e req_periph;
    addr_t   req_address;
    data_t   read_value;
    logic    gnt_data;
    logic    resp_valid;
    logic    resp_data;
    logic    data_req;
    logic    instr_req;
    logic    take_data;
    logic    take_instr;

    // the side whose response is being returned still holds its request.
    assign data_req   = (data_read || data_write) && !(resp_valid && resp_data);
    assign instr_req  = instr_read && !(resp_valid && !resp_data);
    assign take_data  = (state == st_idle) && data_req;
    assign take_instr = (state == st_idle) && !data_req && instr_req;

    assign req_address = data_req ? data_address : instr_address;

    always_comb begin
        if (req_address[31:ram_span_bits] == ram_base[31:ram_span_bits])
            req_periph = periph_ram;
        else if (req_address[31:leds_span_bits] == leds_base[31:leds_span_bits])
            req_periph = periph_leds;
        else if (req_address[31:uart_span_bits] == uart_base[31:uart_span_bits])
            req_periph = periph_uart;
        else if (req_address[31:timer_span_bits] == timer_base[31:timer_span_bits])
            req_periph = periph_timer;
        else
            req_periph = periph_none;
    end

    assign bus.ram_sel   = (sel_q == periph_ram);
    assign bus.leds_sel  = (sel_q == periph_leds);
    assign bus.uart_sel  = (sel_q == periph_uart);
    assign bus.timer_sel = (sel_q == periph_timer);

    assign read_value = bus.ram_read_value | bus.leds_read_value |
                        bus.uart_read_value | bus.timer_read_value;

    always_ff @(posedge pll_clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= st_idle;
            sel_q       <= periph_none;
            bus.read    <= 1'b0;
            bus.write   <= 1'b0;
            gnt_data    <= 1'b0;
            resp_valid  <= 1'b0;
            resp_data   <= 1'b0;
            data_ready  <= 1'b0;
            instr_ready <= 1'b0;
        end else begin
            data_ready  <= resp_valid && resp_data;
            instr_ready <= resp_valid && !resp_data;
            resp_valid  <= (state == st_access);
            resp_data   <= gnt_data;
            case (state)
                st_idle: begin
                    if (take_data || take_instr) begin
                        state     <= st_access;
                        gnt_data  <= take_data;
                        sel_q     <= req_periph;
                        bus.read  <= take_data ? (data_read && !data_write) : 1'b1;
                        bus.write <= take_data && data_write;
                    end
                end
                st_access: begin
                    // the bus is held for one cycle only.
                    state     <= st_idle;
                    sel_q     <= periph_none;
                    bus.read  <= 1'b0;
                    bus.write <= 1'b0;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge pll_clk) begin
        if (take_data || take_instr) begin
            bus.address     <= req_address;
            bus.write_mask  <= take_data ? data_write_mask : '0;
            bus.write_value <= take_data ? data_write_value : '0;
        end
        if (resp_valid && resp_data)
            data_read_value <= read_value;
        if (resp_valid && !resp_data)
            instr_read_value <= read_value;
    end

endmodule

//--- flist.f
soc_pkg.sv
mem_bus_if.sv
bus_arbiter.sv
ram.sv
uart.sv
sys_regs.sv
soc_top.sv
soc_assertions.sv
soc_tb.sv

//--- mem_bus_if.sv
interface mem_bus_if import soc_pkg::*; ();

    addr_t address;
    logic  read;
    logic  write;
    mask_t write_mask;
    data_t write_value;

    logic ram_sel;
    logic leds_sel;
    logic uart_sel;
    logic timer_sel;

    // unselected peripherals return zero so the arbiter can OR these.
    data_t ram_read_value;
    data_t leds_read_value;
    data_t uart_read_value;
    data_t timer_read_value;

    modport master (
        output address, read, write, write_mask, write_value,
        output ram_sel, leds_sel, uart_sel, timer_sel,
        input  ram_read_value, leds_read_value, uart_read_value, timer_read_value
    );

    modport slave (
        input  address, read, write, write_mask, write_value,
        input  ram_sel, leds_sel, uart_sel, timer_sel,
        output ram_read_value, leds_read_value, uart_read_value, timer_read_value
    );

    modport monitor (
        input address, read, write, write_mask, write_value,
        input ram_sel, leds_sel, uart_sel, timer_sel,
        input ram_read_value, leds_read_value, uart_read_value, timer_read_value
    );

endinterface

//--- ram.sv
module ram import soc_pkg::*; (
    input  logic     pll_clk,
    mem_bus_if.slave bus
);

    data_t mem [ram_words];
    logic [ram_addr_bits-1:0] index;

    // upper address bits are ignored, so the window aliases.
    assign index = bus.address[ram_addr_bits+1:2];

    always_ff @(posedge pll_clk) begin
        if (bus.ram_sel && bus.write) begin
            for (int i = 0; i < 4; i++) begin
                if (bus.write_mask[i])
                    mem[index][8*i +: 8] <= bus.write_value[8*i +: 8];
            end
        end
    end

    always_ff @(posedge pll_clk) begin
        if (bus.ram_sel)
            bus.ram_read_value <= mem[index];
        else
            bus.ram_read_value <= '0;
    end

endmodule

//--- soc_assertions.sv
module soc_assertions (
    input logic       pll_clk,
    input logic       rst_n,
    input logic       take_data,
    input logic       take_instr,
    input logic       data_ready,
    input logic       instr_ready,
    input logic       mem_read,
    input logic       mem_write,
    input logic [3:0] selects
);

    timeunit 1ns;
    timeprecision 1ps;

    int failures = 0;

    ready_exclusive: assert property (@(posedge pll_clk) disable iff (!rst_n)
        !(data_ready && instr_ready))
    else begin
        failures++;
        $error("data and instruction ready high together");
    end

    // ready is registered two edges after the grant, so it is sampled on the third.
    data_latency: assert property (@(posedge pll_clk) disable iff (!rst_n)
        take_data |-> ##3 data_ready)
    else begin
        failures++;
        $error("data ready missing after grant");
    end

    instr_latency: assert property (@(posedge pll_clk) disable iff (!rst_n)
        take_instr |-> ##3 instr_ready)
    else begin
        failures++;
        $error("instruction ready missing after grant");
    end

    data_origin: assert property (@(posedge pll_clk) disable iff (!rst_n)
        data_ready |-> $past(take_data, 3))
    else begin
        failures++;
        $error("data ready without a grant three edges earlier");
    end

    instr_origin: assert property (@(posedge pll_clk) disable iff (!rst_n)
        instr_ready |-> $past(take_instr, 3))
    else begin
        failures++;
        $error("instruction ready without a grant three edges earlier");
    end

    one_select: assert property (@(posedge pll_clk) disable iff (!rst_n)
        $onehot0(selects))
    else begin
        failures++;
        $error("more than one peripheral selected");
    end

    read_write_exclusive: assert property (@(posedge pll_clk) disable iff (!rst_n)
        !(mem_read && mem_write))
    else begin
        failures++;
        $error("bus read and write high together");
    end

endmodule

bind bus_arbiter soc_assertions assertions_i (
    .pll_clk     (pll_clk),
    .rst_n       (rst_n),
    .take_data   (take_data),
    .take_instr  (take_instr),
    .data_ready  (data_ready),
    .instr_ready (instr_ready),
    .mem_read    (bus.read),
    .mem_write   (bus.write),
    .selects     ({bus.ram_sel, bus.leds_sel, bus.uart_sel, bus.timer_sel})
);

//--- soc_pkg.sv
package soc_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  mask_t;

    // ram depth in words, indexed by address bits above the byte lanes.
    localparam int ram_words     = 1024;
    localparam int ram_addr_bits = $clog2(ram_words);

    // address map, each window given by its base and its span in address bits.
    localparam addr_t ram_base        = 32'h0000_0000;
    localparam int    ram_span_bits   = 16;
    localparam addr_t leds_base       = 32'h0001_0000;
    localparam int    leds_span_bits  = 2;
    localparam addr_t uart_base       = 32'h0002_0000;
    localparam int    uart_span_bits  = 4;
    localparam addr_t timer_base      = 32'h0003_0000;
    localparam int    timer_span_bits = 4;

    // uart registers; status bit 0 is tx busy, bit 1 is rx valid.
    localparam logic [3:0] uart_tx_ofs     = 4'h0;
    localparam logic [3:0] uart_status_ofs = 4'h4;
    localparam logic [3:0] uart_rx_ofs     = 4'h8;

    localparam logic [3:0] timer_lo_ofs = 4'h0;
    localparam logic [3:0] timer_hi_ofs = 4'h4;

    // clock cycles per serial bit, and the bit counter limits.
    localparam int uart_divisor    = 16;
    localparam int uart_baud_bits  = $clog2(uart_divisor);
    localparam int uart_frame_bits = 10;
    localparam logic [uart_baud_bits-1:0] uart_baud_last = uart_baud_bits'(uart_divisor - 1);
    localparam logic [uart_baud_bits-1:0] uart_baud_half = uart_baud_bits'(uart_divisor / 2 - 1);

    typedef enum logic [2:0] {
        periph_ram,
        periph_leds,
        periph_uart,
        periph_timer,
        periph_none
    } periph_e;

endpackage

//--- soc_tb.sv
module soc_tb import soc_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period = 8;
    localparam int max_wait = 16;
    // 300 bus transactions of 4 cycles, 3 uart frames and the reset.
    localparam int test_cycles = 10 + 300 * 4 + 3 * 160;

    logic       pll_clk;
    logic       rst_n;
    addr_t      instr_address;
    logic       instr_read;
    data_t      instr_read_value;
    logic       instr_ready;
    addr_t      data_address;
    logic       data_read;
    logic       data_write;
    mask_t      data_write_mask;
    data_t      data_write_value;
    data_t      data_read_value;
    logic       data_ready;
    logic       uart_line;
    logic [7:0] leds;

    int    errors = 0;
    data_t shadow_ram [ram_words];
    logic [7:0] shadow_leds = '0;
    addr_t written_q [$];
    addr_t read_addr_q [$];
    data_t got_q [$];
    data_t exp_q [$];

    soc_top dut_i (
        .pll_clk          (pll_clk),
        .rst_n            (rst_n),
        .instr_address    (instr_address),
        .instr_read       (instr_read),
        .instr_read_value (instr_read_value),
        .instr_ready      (instr_ready),
        .data_address     (data_address),
        .data_read        (data_read),
        .data_write       (data_write),
        .data_write_mask  (data_write_mask),
        .data_write_value (data_write_value),
        .data_read_value  (data_read_value),
        .data_ready       (data_ready),
        .uart_rx          (uart_line),
        .uart_tx          (uart_line),
        .leds             (leds)
    );

    initial begin
        pll_clk = 1'b0;
        forever #(clk_period / 2) pll_clk = ~pll_clk;
    end

    task automatic check_equal(input data_t got, input data_t expected, input string what);
        if (got !== expected) begin
            errors++;
            $display("mismatch at %0t: %s, got %h expected %h", $time, what, got, expected);
        end
    endtask

    // expected read word from the address map and the shadow state.
    function automatic data_t ref_read(addr_t address);
        if (address[31:16] == ram_base[31:16])
            return shadow_ram[address[11:2]];
        if (address[31:2] == leds_base[31:2])
            return {24'b0, shadow_leds};
        return '0;
    endfunction

    function automatic logic is_modeled(addr_t address);
        return address[31:4] != uart_base[31:4] && address[31:4] != timer_base[31:4];
    endfunction

    function automatic void apply_write(addr_t address, mask_t mask, data_t value);
        if (address[31:16] == ram_base[31:16]) begin
            for (int i = 0; i < 4; i++) begin
                if (mask[i])
                    shadow_ram[address[11:2]][8*i +: 8] = value[8*i +: 8];
            end
        end else if (address[31:2] == leds_base[31:2] && mask[0]) begin
            shadow_leds = value[7:0];
        end
    endfunction

    function automatic void queue_read(addr_t address, data_t value);
        read_addr_q.push_back(address);
        got_q.push_back(value);
        exp_q.push_back(ref_read(address));
    endfunction

    // called just after a falling edge; returns at the edge where ready is seen.
    task automatic data_access(input addr_t address, input logic write, input mask_t mask,
                               input data_t value, output data_t result, output int waits);
        waits = 0;
        data_address = address;
        data_read = !write;
        data_write = write;
        data_write_mask = mask;
        data_write_value = value;
        do begin
            @(negedge pll_clk);
            waits++;
        end while (!data_ready && waits < max_wait);
        if (!data_ready) begin
            errors++;
            $display("data request to %h got no ready within %0d cycles", address, max_wait);
        end
        result = data_read_value;
        data_read = 1'b0;
        data_write = 1'b0;
        if (write)
            apply_write(address, mask, value);
        else if (is_modeled(address))
            queue_read(address, result);
    endtask

    task automatic instr_fetch(input addr_t address, output data_t result, output int waits);
        waits = 0;
        instr_address = address;
        instr_read = 1'b1;
        do begin
            @(negedge pll_clk);
            waits++;
        end while (!instr_ready && waits < max_wait);
        if (!instr_ready) begin
            errors++;
            $display("fetch from %h got no ready within %0d cycles", address, max_wait);
        end
        result = instr_read_value;
        instr_read = 1'b0;
        queue_read(address, result);
    endtask

    task automatic write_word(input addr_t address, input mask_t mask, input data_t value);
        data_t unused;
        int waits;
        data_access(address, 1'b1, mask, value, unused, waits);
    endtask

    task automatic read_word(input addr_t address, output data_t result);
        int waits;
        data_access(address, 1'b0, '0, '0, result, waits);
    endtask

    function automatic addr_t alias_of(addr_t address);
        return {16'b0, 4'($urandom), address[11:0]};
    endfunction

    task automatic finish_run();
        int total;
        total = errors + dut_i.arbiter_i.assertions_i.failures;
        $display("check errors: %0d, assertion failures: %0d", errors,
                 dut_i.arbiter_i.assertions_i.failures);
        if (total == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    endtask

    initial begin
        forever begin
            wait (got_q.size() != 0);
            check_equal(got_q.pop_front(), exp_q.pop_front(),
                        $sformatf("read of %h", read_addr_q.pop_front()));
        end
    end

    initial begin
        #(2 * test_cycles * clk_period);
        errors++;
        $display("timeout: tests still running after %0d cycles", 2 * test_cycles);
        finish_run();
    end

    initial begin
        data_t      value;
        data_t      lo_first;
        data_t      lo_second;
        data_t      fetched;
        addr_t      address;
        logic [7:0] tx_byte;
        int         waits;
        int         instr_waits;
        longint     start_time;

        void'($urandom(32'h52ae_ef1d));
        rst_n = 1'b0;
        instr_address = '0;
        instr_read = 1'b0;
        data_address = '0;
        data_read = 1'b0;
        data_write = 1'b0;
        data_write_mask = '0;
        data_write_value = '0;
        repeat (10) @(negedge pll_clk);
        rst_n = 1'b1;
        @(negedge pll_clk);

        // ram byte masks, with reads through aliased addresses.
        for (int i = 0; i < 12; i++) begin
            address = (i == 0) ? ram_base : ram_base | {16'b0, 16'($urandom) & 16'hfffc};
            write_word(address, 4'hf, $urandom);
            written_q.push_back(address);
        end
        for (int i = 0; i < 30; i++)
            write_word(alias_of(written_q[$urandom_range(0, 11)]), 4'($urandom), $urandom);
        for (int i = 0; i < 30; i++)
            read_word(alias_of(written_q[$urandom_range(0, 11)]), value);

        // data and instruction requests raised together.
        for (int i = 0; i < 4; i++) begin
            fork
                data_access(written_q[$urandom_range(0, 11)], 1'b0, '0, '0, value, waits);
                instr_fetch(written_q[$urandom_range(0, 11)], fetched, instr_waits);
            join
            check_equal(waits, 3, "data ready latency");
            check_equal(instr_waits, 5, "instruction ready latency");
        end

        write_word(leds_base, 4'b0001, 32'h0000_00a5);
        check_equal({24'b0, leds}, 32'h0000_00a5, "leds port after write");
        read_word(leds_base, value);
        write_word(leds_base, 4'b1110, 32'h0000_003c);
        check_equal({24'b0, leds}, 32'h0000_00a5, "leds port after masked write");
        read_word(leds_base, value);

        read_word(timer_base | 32'(timer_lo_ofs), lo_first);
        read_word(timer_base | 32'(timer_lo_ofs), lo_second);
        check_equal(lo_second - lo_first, 32'd3, "timer_lo step");
        read_word(timer_base | 32'(timer_hi_ofs), value);
        check_equal(value, '0, "timer_hi");

        // uart frames looped back from tx to rx.
        repeat (3) begin
            tx_byte = 8'($urandom);
            write_word(uart_base | 32'(uart_tx_ofs), 4'h1, {24'b0, tx_byte});
            read_word(uart_base | 32'(uart_status_ofs), value);
            check_equal(value & 32'h1, 32'h1, "tx busy after write");
            start_time = $time;
            do begin
                read_word(uart_base | 32'(uart_status_ofs), value);
            end while (value[1:0] != 2'b10 && ($time - start_time) < 200 * clk_period);
            check_equal(value, 32'h2, "status at end of frame");
            read_word(uart_base | 32'(uart_rx_ofs), value);
            check_equal(value, {24'b0, tx_byte}, "received byte");
            read_word(uart_base | 32'(uart_status_ofs), value);
            check_equal(value & 32'h2, 32'h0, "rx valid after rx read");
        end

        read_word(32'h0004_0000, value);
        write_word(32'h0004_0000, 4'hf, 32'hdead_beef);
        foreach (written_q[i])
            read_word(written_q[i], value);
        read_word(leds_base, value);
        check_equal({24'b0, leds}, {24'b0, shadow_leds}, "leds port after unmapped write");

        wait (got_q.size() == 0);
        finish_run();
    end

endmodule

//--- soc_top.sv
module soc_top import soc_pkg::*; (
    input  logic       pll_clk,
    input  logic       rst_n,

    input  addr_t      instr_address,
    input  logic       instr_read,
    output data_t      instr_read_value,
    output logic       instr_ready,

    input  addr_t      data_address,
    input  logic       data_read,
    input  logic       data_write,
    input  mask_t      data_write_mask,
    input  data_t      data_write_value,
    output data_t      data_read_value,
    output logic       data_ready,

    input  logic       uart_rx,
    output logic       uart_tx,
    output logic [7:0] leds
);

    mem_bus_if bus_i ();

    bus_arbiter arbiter_i (
        .pll_clk          (pll_clk),
        .rst_n            (rst_n),
        .instr_address    (instr_address),
        .instr_read       (instr_read),
        .instr_read_value (instr_read_value),
        .instr_ready      (instr_ready),
        .data_address     (data_address),
        .data_read        (data_read),
        .data_write       (data_write),
        .data_write_mask  (data_write_mask),
        .data_write_value (data_write_value),
        .data_read_value  (data_read_value),
        .data_ready       (data_ready),
        .bus              (bus_i.master)
    );

    ram ram_i (
        .pll_clk (pll_clk),
        .bus     (bus_i.slave)
    );

    uart uart_i (
        .pll_clk (pll_clk),
        .rst_n   (rst_n),
        .rx      (uart_rx),
        .tx      (uart_tx),
        .bus     (bus_i.slave)
    );

    // leds and the cycle counter share one register block.
    sys_regs sys_regs_i (
        .pll_clk (pll_clk),
        .rst_n   (rst_n),
        .leds    (leds),
        .bus     (bus_i.slave)
    );

endmodule

//--- sys_regs.sv
module sys_regs import soc_pkg::*; (
    input  logic       pll_clk,
    input  logic       rst_n,
    output logic [7:0] leds,
    mem_bus_if.slave   bus
);

    logic [63:0] cycle;

    always_ff @(posedge pll_clk or negedge rst_n) begin
        if (!rst_n)
            leds <= '0;
        else if (bus.leds_sel && bus.write && bus.write_mask[0])
            leds <= bus.write_value[7:0];
    end

    // free-running since reset.
    always_ff @(posedge pll_clk or negedge rst_n) begin
        if (!rst_n)
            cycle <= '0;
        else
            cycle <= cycle + 64'd1;
    end

    always_ff @(posedge pll_clk) begin
        if (bus.leds_sel && bus.read)
            bus.leds_read_value <= {24'b0, leds};
        else
            bus.leds_read_value <= '0;
    end

    // the count seen here is the value before this edge's increment.
    always_ff @(posedge pll_clk) begin
        if (bus.timer_sel && bus.read) begin
            case (bus.address[3:0])
                timer_lo_ofs: bus.timer_read_value <= cycle[31:0];
                timer_hi_ofs: bus.timer_read_value <= cycle[63:32];
                default:      bus.timer_read_value <= '0;
            endcase
        end else begin
            bus.timer_read_value <= '0;
        end
    end

endmodule

//--- uart.sv
module uart import soc_pkg::*; (
    input  logic     pll_clk,
    input  logic     rst_n,
    input  logic     rx,
    output logic     tx,
    mem_bus_if.slave bus
);

    logic [3:0] ofs;
    logic       tx_start;
    logic       rx_take;

    logic                      tx_busy;
    logic [uart_frame_bits-1:0] tx_shift;
    logic [3:0]                tx_bits;
    logic [uart_baud_bits-1:0] tx_baud;

    logic                      rx_meta;
    logic                      rx_sync;
    logic                      rx_active;
    logic                      rx_valid;
    logic [3:0]                rx_bits;
    logic [uart_baud_bits-1:0] rx_baud;
    logic [7:0]                rx_shift;
    logic [7:0]                rx_data;

    assign ofs      = bus.address[3:0];
    assign tx_start = bus.uart_sel && bus.write && bus.write_mask[0] &&
                      (ofs == uart_tx_ofs) && !tx_busy;
    assign rx_take  = bus.uart_sel && bus.read && (ofs == uart_rx_ofs);

    // line idles high between frames.
    assign tx = tx_busy ? tx_shift[0] : 1'b1;

    always_ff @(posedge pll_clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_busy <= 1'b0;
            tx_bits <= '0;
            tx_baud <= '0;
        end else if (tx_start) begin
            tx_busy <= 1'b1;
            tx_bits <= 4'(uart_frame_bits);
            tx_baud <= '0;
        end else if (tx_busy) begin
            if (tx_baud == uart_baud_last) begin
                tx_baud <= '0;
                tx_bits <= tx_bits - 1'b1;
                if (tx_bits == 4'd1)
                    tx_busy <= 1'b0;
            end else begin
                tx_baud <= tx_baud + 1'b1;
            end
        end
    end

    // start bit, 8 data bits lsb first, stop bit.
    always_ff @(posedge pll_clk) begin
        if (tx_start)
            tx_shift <= {1'b1, bus.write_value[7:0], 1'b0};
        else if (tx_busy && tx_baud == uart_baud_last)
            tx_shift <= {1'b1, tx_shift[uart_frame_bits-1:1]};
    end

    always_ff @(posedge pll_clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge pll_clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_active <= 1'b0;
            rx_valid  <= 1'b0;
            rx_bits   <= '0;
            rx_baud   <= '0;
        end else begin
            if (rx_take)
                rx_valid <= 1'b0;
            if (!rx_active) begin
                if (!rx_sync) begin
                    rx_active <= 1'b1;
                    rx_bits   <= '0;
                    rx_baud   <= '0;
                end
            end else begin
                rx_baud <= (rx_baud == uart_baud_last) ? '0 : rx_baud + 1'b1;
                if (rx_baud == uart_baud_last)
                    rx_bits <= rx_bits + 1'b1;
                if (rx_baud == uart_baud_half) begin
                    // a start bit that is high again at mid-bit was a glitch.
                    if (rx_bits == '0 && rx_sync) begin
                        rx_active <= 1'b0;
                    end else if (rx_bits == 4'(uart_frame_bits - 1)) begin
                        rx_active <= 1'b0;
                        if (rx_sync)
                            rx_valid <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge pll_clk) begin
        if (rx_active && rx_baud == uart_baud_half) begin
            if (rx_bits >= 4'd1 && rx_bits <= 4'd8)
                rx_shift <= {rx_sync, rx_shift[7:1]};
            if (rx_bits == 4'(uart_frame_bits - 1) && rx_sync)
                rx_data <= rx_shift;
        end
    end

    always_ff @(posedge pll_clk) begin
        if (bus.uart_sel && bus.read) begin
            case (ofs)
                uart_status_ofs: bus.uart_read_value <= {30'b0, rx_valid, tx_busy};
                uart_rx_ofs:     bus.uart_read_value <= {24'b0, rx_data};
                default:         bus.uart_read_value <= '0;
            endcase
        end else begin
            bus.uart_read_value <= '0;
        end
    end

endmodule
